//--- dv/thresholding_axi_tb.sv
//------------------------------
// Testbench for thresholding_axi driven by dv/thresholding_testdata.txt
// Run from the project root so the data file path resolves
// Stream beats counted from reset so channel n mod 4 follows file order
//------------------------------
`timescale 1ns/1ps

module thresholding_axi_tb;
	import thr_cfg_pkg::*;
	import axil_pkg::*;

	logic	ap_clk;
	logic	reset;
	logic	s_axilite_awvalid, s_axilite_awready;
	axil_addr_t	s_axilite_awaddr;
	logic	s_axilite_wvalid, s_axilite_wready;
	axil_data_t	s_axilite_wdata;
	axil_strb_t	s_axilite_wstrb;
	logic	s_axilite_bvalid, s_axilite_bready;
	axil_resp_t	s_axilite_bresp;
	logic	s_axilite_arvalid, s_axilite_arready;
	axil_addr_t	s_axilite_araddr;
	logic	s_axilite_rvalid, s_axilite_rready;
	axil_data_t	s_axilite_rdata;
	axil_resp_t	s_axilite_rresp;
	logic	s_axis_tready, s_axis_tvalid;
	s_tdata_t	s_axis_tdata;
	logic	m_axis_tready, m_axis_tvalid;
	m_tdata_t	m_axis_tdata;

	//------------------------------
	// Command list and scoreboard
	//------------------------------
	byte	op_q [$];
	logic [31:0]	a_q [$];
	logic [31:0]	b_q [$];
	int	ln_q [$];            // Source line of each command
	level_t	exp_q [$];       // Levels still owed by the DUT
	string	name_q [$];
	level_t	exp_lvl;
	string	exp_name;
	int	val_errs;
	int	other_errs;
	int	bp_left;            // Samples left in back-pressure mode
	int	seed_ret;
	logic	loaded;

	thresholding_axi dut0 (.*);

	initial begin
		ap_clk = 1'b0;
		forever #10 ap_clk = ~ap_clk;  // 20 ns period
	end

	// Reads the command lines and skips '#' notes
	task load_commands;
		int fd;
		int n;
		int ln;
		string line;
		byte op;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("dv/thresholding_testdata.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("Could not open dv/thresholding_testdata.txt");
		end else begin
			ln = 0;
			while ($fgets(line, fd) != 0) begin
				ln++;
				op = "#";
				n = $sscanf(line, "%c %h %h", op, a, b);
				if (n >= 2 && op != "#") begin
					op_q.push_back(op);
					a_q.push_back(a);
					b_q.push_back(b);
					ln_q.push_back(ln);
				end
			end
			$fclose(fd);
		end
	endtask

	task wait_drain;
		while (exp_q.size() > 0) @(negedge ap_clk);
	endtask

	// AW and W offered together and each dropped after its own handshake
	task axi_write(input axil_addr_t addr, input axil_data_t data, input string name);
		logic aw_done;
		logic w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		s_axilite_awaddr = addr;
		s_axilite_wdata = data;
		s_axilite_awvalid = 1'b1;
		s_axilite_wvalid = 1'b1;
		while (!(aw_done && w_done)) begin
			@(posedge ap_clk);
			if (s_axilite_awvalid && s_axilite_awready) aw_done = 1'b1;
			if (s_axilite_wvalid && s_axilite_wready) w_done = 1'b1;
			@(negedge ap_clk);
			if (aw_done) s_axilite_awvalid = 1'b0;
			if (w_done) s_axilite_wvalid = 1'b0;
		end
		s_axilite_bready = 1'b1;
		@(posedge ap_clk);
		while (!s_axilite_bvalid) @(posedge ap_clk);
		if (s_axilite_bresp !== 2'b00) begin  // OKAY
			val_errs++;
			$display("ERR %s bresp expected 0 actual %0h", name, s_axilite_bresp);
		end
		@(negedge ap_clk);
		s_axilite_bready = 1'b0;
	endtask

	task axi_read(input axil_addr_t addr, input axil_data_t expd, input string name);
		s_axilite_araddr = addr;
		s_axilite_arvalid = 1'b1;
		@(posedge ap_clk);
		while (!s_axilite_arready) @(posedge ap_clk);
		@(negedge ap_clk);
		s_axilite_arvalid = 1'b0;
		s_axilite_rready = 1'b1;
		@(posedge ap_clk);
		while (!s_axilite_rvalid) @(posedge ap_clk);
		if (s_axilite_rdata !== expd) begin
			val_errs++;
			$display("ERR %s rdata expected %0h actual %0h", name, expd, s_axilite_rdata);
		end
		if (s_axilite_rresp !== 2'b00) begin  // OKAY
			val_errs++;
			$display("ERR %s rresp expected 0 actual %0h", name, s_axilite_rresp);
		end
		@(negedge ap_clk);
		s_axilite_rready = 1'b0;
	endtask

	// Random idle gap then hold the beat until accepted
	task send_sample(input sample_t smp);
		int gap;
		gap = $urandom % 3;
		repeat (gap) @(negedge ap_clk);
		s_axis_tdata = s_tdata_t'(smp);
		s_axis_tvalid = 1'b1;
		@(posedge ap_clk);
		while (!s_axis_tready) @(posedge ap_clk);
		@(negedge ap_clk);
		s_axis_tvalid = 1'b0;
	endtask

	//------------------------------
	// Output side
	//------------------------------
	initial begin
		forever begin
			@(negedge ap_clk);
			if (bp_left > 0) m_axis_tready = $urandom % 2;  // Random stalls
			else m_axis_tready = 1'b1;
		end
	end

	always @(posedge ap_clk) begin
		if (!reset && m_axis_tvalid && m_axis_tready) begin
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("Output beat %0h came out with no sample waiting for it", m_axis_tdata);
			end else begin
				exp_lvl = exp_q.pop_front();
				exp_name = name_q.pop_front();
				if (m_axis_tdata !== m_tdata_t'(exp_lvl)) begin
					val_errs++;
					$display("ERR %s expected %0h actual %0h", exp_name, exp_lvl, m_axis_tdata);
				end
			end
		end
	end

	// Watchdog allows 200 cycles per command line
	initial begin
		wait (loaded);
		repeat (ln_q.size() * 200 + 20) @(posedge ap_clk);
		$display("Timeout: run still busy after %0d cycles", ln_q.size() * 200 + 20);
		$display("Result: FAILED");
		$finish;
	end

	//------------------------------
	// Main sequence
	//------------------------------
	initial begin
		seed_ret = $urandom(32'h1e31);
		reset = 1'b1;
		s_axilite_awvalid = 1'b0;
		s_axilite_awaddr = '0;
		s_axilite_wvalid = 1'b0;
		s_axilite_wdata = '0;
		s_axilite_wstrb = '1;
		s_axilite_bready = 1'b0;
		s_axilite_arvalid = 1'b0;
		s_axilite_araddr = '0;
		s_axilite_rready = 1'b0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata = '0;
		m_axis_tready = 1'b1;
		val_errs = 0;
		other_errs = 0;
		bp_left = 0;
		loaded = 1'b0;
		load_commands();
		loaded = 1'b1;
		repeat (4) @(negedge ap_clk);
		reset = 1'b0;
		@(negedge ap_clk);
		foreach (op_q[k]) begin
			case (op_q[k])
				"W": begin
					wait_drain();  // Table changes only between bursts
					axi_write(axil_addr_t'(a_q[k]), b_q[k], $sformatf("write line %0d", ln_q[k]));
				end
				"R": begin
					wait_drain();
					axi_read(axil_addr_t'(a_q[k]), b_q[k], $sformatf("read line %0d", ln_q[k]));
				end
				"S": begin
					exp_q.push_back(level_t'(b_q[k]));
					name_q.push_back($sformatf("sample line %0d", ln_q[k]));
					send_sample(sample_t'(a_q[k]));
					if (bp_left > 0) bp_left--;
				end
				"B": bp_left = a_q[k];
				default: begin
					other_errs++;
					$display("Unknown command on line %0d of the testdata file", ln_q[k]);
				end
			endcase
		end
		wait_drain();
		repeat (5) @(negedge ap_clk);  // Catch stray extra beats
		$display("Errors: %0d value, %0d other", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule : thresholding_axi_tb

//--- dv/thresholding_testdata.txt
# Columns: op a b, all numbers hex. W addr data | R addr expected | S sample level | B count
# Address = channel*10 + index*4. Beat n of the stream uses channel n mod 4
R 00 40
R 14 81
R 28 c2
R 30 43
R 0c 0
R 3c 0
S 00 0
S 41 1
S 41 0
S ff 3
S 80 2
S 80 1
S c2 3
S c2 2
B 8
S c0 3
S c0 2
S 42 1
S 42 0
S 3f 0
S 81 2
S 81 1
S c3 3
W 00 1210
R 00 10
W 04 120
W 08 30
W 3c ff
R 04 20
R 3c 0
R 30 43
S 20 2
S 20 0
S 42 1
S ff 3
S 30 3

//--- logic/axil_cfg_bridge.sv
//------------------------------
// AXI-lite slave to config strobes
// One write and one read in flight at most, write wins a tie
// WSTRB ignored, write data cut to K bits, responses always OKAY
//------------------------------
`timescale 1ns/1ps

module axil_cfg_bridge (
	input	logic	ap_clk,
	input	logic	reset,

	// AXI-lite write
	input	logic	s_axilite_awvalid,
	output	logic	s_axilite_awready,
	input	axil_pkg::axil_addr_t	s_axilite_awaddr,
	input	logic	s_axilite_wvalid,
	output	logic	s_axilite_wready,
	input	axil_pkg::axil_data_t	s_axilite_wdata,
	input	axil_pkg::axil_strb_t	s_axilite_wstrb,
	output	logic	s_axilite_bvalid,
	input	logic	s_axilite_bready,
	output	axil_pkg::axil_resp_t	s_axilite_bresp,

	// AXI-lite read
	input	logic	s_axilite_arvalid,
	output	logic	s_axilite_arready,
	input	axil_pkg::axil_addr_t	s_axilite_araddr,
	output	logic	s_axilite_rvalid,
	input	logic	s_axilite_rready,
	output	axil_pkg::axil_data_t	s_axilite_rdata,
	output	axil_pkg::axil_resp_t	s_axilite_rresp,

	// Config port
	output	logic	cfg_en,
	output	logic	cfg_we,
	output	thr_cfg_pkg::chan_t	cfg_ch,
	output	thr_cfg_pkg::tidx_t	cfg_idx,
	output	thr_cfg_pkg::sample_t	cfg_d,
	input	logic	cfg_rack,
	input	thr_cfg_pkg::sample_t	cfg_q
);
	import thr_cfg_pkg::*;
	import axil_pkg::*;

	typedef enum logic [1:0] {wr_idle, wr_issue, wr_resp} wr_state_t;
	typedef enum logic [1:0] {rd_idle, rd_issue, rd_wait, rd_resp} rd_state_t;

	wr_state_t	wr_state;
	rd_state_t	rd_state;
	logic	aw_full;      // AW latched, waiting for W
	logic	w_full;       // W latched, waiting for AW
	logic	aw_hs;
	logic	w_hs;
	logic	ar_hs;
	logic	wr_go;        // Write strobe this cycle
	logic	rd_go;        // Read strobe this cycle
	axil_addr_t	aw_addr_q;
	axil_addr_t	ar_addr_q;
	axil_addr_t	cfg_addr;
	sample_t	wdata_q;
	sample_t	rdata_q;

	//------------------------------
	// Handshakes
	//------------------------------
	assign s_axilite_awready = (wr_state == wr_idle) && !aw_full;
	assign s_axilite_wready = (wr_state == wr_idle) && !w_full;
	assign s_axilite_arready = (rd_state == rd_idle);  // One read outstanding
	assign aw_hs = s_axilite_awvalid && s_axilite_awready;
	assign w_hs = s_axilite_wvalid && s_axilite_wready;
	assign ar_hs = s_axilite_arvalid && s_axilite_arready;

	// Write FSM
	always_ff @(posedge ap_clk) begin
		if (reset) begin
			wr_state <= wr_idle;
			aw_full <= 1'b0;
			w_full <= 1'b0;
		end else begin
			case (wr_state)
				wr_idle: begin
					if ((aw_full || aw_hs) && (w_full || w_hs)) begin  // Both halves held
						wr_state <= wr_issue;
						aw_full <= 1'b0;
						w_full <= 1'b0;
					end else begin
						if (aw_hs) aw_full <= 1'b1;
						if (w_hs) w_full <= 1'b1;
					end
				end
				wr_issue: wr_state <= wr_resp;  // Strobe is one cycle
				wr_resp: if (s_axilite_bready) wr_state <= wr_idle;
				default: wr_state <= wr_idle;
			endcase
		end
	end

	// Read FSM
	always_ff @(posedge ap_clk) begin
		if (reset) begin
			rd_state <= rd_idle;
		end else begin
			case (rd_state)
				rd_idle: if (ar_hs) rd_state <= rd_issue;
				rd_issue: if (!wr_go) rd_state <= rd_wait;  // Yield to a write
				rd_wait: if (cfg_rack) rd_state <= rd_resp;
				rd_resp: if (s_axilite_rready) rd_state <= rd_idle;
				default: rd_state <= rd_idle;
			endcase
		end
	end

	// Address and data holding regs
	always_ff @(posedge ap_clk) begin
		if (aw_hs) aw_addr_q <= s_axilite_awaddr;
		if (w_hs) wdata_q <= s_axilite_wdata[thr_k-1:0];  // Truncate to K bits
		if (ar_hs) ar_addr_q <= s_axilite_araddr;
		if ((rd_state == rd_wait) && cfg_rack) rdata_q <= cfg_q;
	end

	//------------------------------
	// Config strobes
	//------------------------------
	assign wr_go = (wr_state == wr_issue);
	assign rd_go = (rd_state == rd_issue) && !wr_go;
	assign cfg_en = wr_go || rd_go;
	assign cfg_we = wr_go;
	assign cfg_addr = wr_go ? aw_addr_q : ar_addr_q;
	assign cfg_idx = cfg_addr[axil_byte_bits +: axil_idx_bits];  // Byte bits dropped
	assign cfg_ch = cfg_addr[axil_byte_bits + axil_idx_bits +: axil_ch_bits];
	assign cfg_d = wdata_q;

	// Responses
	assign s_axilite_bvalid = (wr_state == wr_resp);
	assign s_axilite_bresp = resp_okay;
	assign s_axilite_rvalid = (rd_state == rd_resp);
	assign s_axilite_rdata = {{(axil_data_bits - thr_k){1'b0}}, rdata_q};  // Zero extend
	assign s_axilite_rresp = resp_okay;

endmodule : axil_cfg_bridge

//--- logic/axil_pkg.sv
//------------------------------
// AXI-lite widths and the threshold address map
// Byte address = {channel, index, 2 byte bits}, byte bits ignored
//------------------------------

package axil_pkg;

	localparam int unsigned axil_byte_bits = 2;   // Byte select, dropped
	localparam int unsigned axil_idx_bits = 2;    // Threshold index field
	localparam int unsigned axil_ch_bits = 2;     // Channel field
	localparam int unsigned axil_addr_bits = axil_ch_bits + axil_idx_bits + axil_byte_bits;
	localparam int unsigned axil_data_bits = 32;

	typedef logic [axil_addr_bits-1:0] axil_addr_t;    // Byte address
	typedef logic [axil_data_bits-1:0] axil_data_t;    // Data word
	typedef logic [axil_data_bits/8-1:0] axil_strb_t;  // Write strobes, ignored
	typedef logic [1:0] axil_resp_t;

	// Only OKAY is ever returned
	localparam axil_resp_t resp_okay = 2'b00;

endpackage : axil_pkg

//--- logic/thr_cfg_pkg.sv
//------------------------------
// Sizes and types of the threshold kernel, fixed at K=8, N=2, C=4, PE=1
// Unsigned samples only, output bias is always 0
// Each channel table must be kept in ascending order by software
//------------------------------

package thr_cfg_pkg;

	//------------------------------
	// Kernel sizes
	//------------------------------
	localparam int unsigned thr_k = 8;                  // Sample and threshold width
	localparam int unsigned thr_n = 2;                  // Output precision
	localparam int unsigned thr_c = 4;                  // Channels in rotation
	localparam int unsigned thr_per_ch = 2**thr_n - 1;  // Thresholds per channel
	localparam int unsigned out_bits = thr_n;           // Output level width

	//------------------------------
	// Vector types
	//------------------------------
	typedef logic [thr_k-1:0] sample_t;              // Sample or threshold word
	typedef logic [out_bits-1:0] level_t;            // Thresholds reached
	typedef logic [$clog2(thr_c)-1:0] chan_t;        // Channel index
	typedef logic [thr_n-1:0] tidx_t;                // Threshold index, 3 is unused
	typedef logic [((thr_k+7)/8)*8-1:0] s_tdata_t;    // Input stream, byte padded
	typedef logic [((out_bits+7)/8)*8-1:0] m_tdata_t; // Output stream, byte padded

	// Reset table
	// Entry [c][i] is 64*(i+1) + c
	localparam sample_t thr_init [thr_c][thr_per_ch] = '{
		'{8'd64, 8'd128, 8'd192},  // Channel 0
		'{8'd65, 8'd129, 8'd193},  // Channel 1
		'{8'd66, 8'd130, 8'd194},  // Channel 2
		'{8'd67, 8'd131, 8'd195}   // Channel 3
	};

endpackage : thr_cfg_pkg

//--- logic/threshold_pipe.sv
//------------------------------
// Two-stage compare pipe with round-robin channels
// Beat n uses channel n mod 4, counted from reset
// Whole pipe stalls on output back-pressure, 2 cycles latency
//------------------------------
`timescale 1ns/1ps

module threshold_pipe (
	input	logic	ap_clk,
	input	logic	reset,

	// Table lookup
	output	thr_cfg_pkg::chan_t	lk_ch,
	input	thr_cfg_pkg::sample_t [thr_cfg_pkg::thr_per_ch-1:0]	lk_thr,

	// Input stream
	output	logic	s_axis_tready,
	input	logic	s_axis_tvalid,
	input	thr_cfg_pkg::s_tdata_t	s_axis_tdata,

	// Output stream
	input	logic	m_axis_tready,
	output	logic	m_axis_tvalid,
	output	thr_cfg_pkg::m_tdata_t	m_axis_tdata
);
	import thr_cfg_pkg::*;

	logic	adv;          // Whole pipe moves this cycle
	logic	in_hs;        // Input beat accepted
	chan_t	chan_q;       // Channel of the next input beat

	// Stage 1
	logic	s1_vld;
	sample_t	s1_smp;
	sample_t [thr_per_ch-1:0]	s1_thr;

	// Stage 2
	logic	s2_vld;
	level_t	s2_lvl;
	level_t	cnt;          // Thresholds reached by the stage 1 sample

	//------------------------------
	// Flow control
	//------------------------------
	assign adv = !s2_vld || m_axis_tready;
	assign s_axis_tready = adv;
	assign in_hs = s_axis_tvalid && adv;

	// Channel rotation
	always_ff @(posedge ap_clk) begin
		if (reset) begin
			chan_q <= '0;
		end else if (in_hs) begin
			if (chan_q == chan_t'(thr_c - 1)) begin
				chan_q <= '0;  // Wrap
			end else begin
				chan_q <= chan_q + chan_t'(1);
			end
		end
	end

	assign lk_ch = chan_q;

	//------------------------------
	// Stage 1 registers sample and its thresholds
	//------------------------------
	always_ff @(posedge ap_clk) begin
		if (reset) begin
			s1_vld <= 1'b0;
		end else if (adv) begin
			s1_vld <= s_axis_tvalid;  // Bubble when no input
		end
	end

	always_ff @(posedge ap_clk) begin
		if (in_hs) begin
			s1_smp <= s_axis_tdata[thr_k-1:0];
			s1_thr <= lk_thr;  // Latest table contents
		end
	end

	// Count thresholds at or below the sample
	always_comb begin
		cnt = '0;
		for (int i = 0; i < thr_per_ch; i++) begin
			if (s1_smp >= s1_thr[i]) begin
				cnt = cnt + level_t'(1);
			end
		end
	end

	//------------------------------
	// Stage 2 registers the level
	//------------------------------
	always_ff @(posedge ap_clk) begin
		if (reset) begin
			s2_vld <= 1'b0;
		end else if (adv) begin
			s2_vld <= s1_vld;
		end
	end

	always_ff @(posedge ap_clk) begin
		if (adv && s1_vld) begin
			s2_lvl <= cnt;
		end
	end

	// Output word, level in the low bits
	assign m_axis_tvalid = s2_vld;
	assign m_axis_tdata = {{($bits(m_tdata_t) - out_bits){1'b0}}, s2_lvl};

endmodule : threshold_pipe

//--- logic/threshold_store.sv
//------------------------------
// Threshold table in flops, loaded with thr_init on reset
// Index 3 is a hole: writes dropped, reads give 0
//------------------------------
`timescale 1ns/1ps

module threshold_store (
	input	logic	ap_clk,
	input	logic	reset,

	// Config port
	input	logic	cfg_en,
	input	logic	cfg_we,
	input	thr_cfg_pkg::chan_t	cfg_ch,
	input	thr_cfg_pkg::tidx_t	cfg_idx,
	input	thr_cfg_pkg::sample_t	cfg_d,
	output	logic	cfg_rack,
	output	thr_cfg_pkg::sample_t	cfg_q,

	// Stream lookup, combinational
	input	thr_cfg_pkg::chan_t	lk_ch,
	output	thr_cfg_pkg::sample_t [thr_cfg_pkg::thr_per_ch-1:0]	lk_thr
);
	import thr_cfg_pkg::*;

	sample_t	thr_q [thr_c][thr_per_ch];  // [channel][index]
	logic	idx_ok;                         // Index maps to a real threshold

	assign idx_ok = (cfg_idx < thr_per_ch);

	//------------------------------
	// Table update
	//------------------------------
	always_ff @(posedge ap_clk) begin
		if (reset) begin
			thr_q <= thr_init;
		end else if (cfg_en && cfg_we && idx_ok) begin
			thr_q[cfg_ch][cfg_idx] <= cfg_d;
		end
	end

	// Read ack pulses one cycle after the strobe
	always_ff @(posedge ap_clk) begin
		if (reset) begin
			cfg_rack <= 1'b0;
		end else begin
			cfg_rack <= cfg_en && !cfg_we;
		end
	end

	// Read data, only looked at with cfg_rack
	always_ff @(posedge ap_clk) begin
		if (cfg_en && !cfg_we) begin
			cfg_q <= idx_ok ? thr_q[cfg_ch][cfg_idx] : '0;
		end
	end

	//------------------------------
	// Lookup for the sample entering stage 1
	//------------------------------
	always_comb begin
		for (int i = 0; i < thr_per_ch; i++) begin
			lk_thr[i] = thr_q[lk_ch][i];  // Ascending order by index
		end
	end

endmodule : threshold_store

//--- logic/thresholding_axi.sv
//------------------------------
// Multi-threshold unit with AXI-lite table access
// AXI-stream in and out, one unsigned 8-bit sample per beat
// Reset is synchronous and active high
//------------------------------
`timescale 1ns/1ps

module thresholding_axi (
	input	logic	ap_clk,
	input	logic	reset,

	//------------------------------
	// AXI-lite
	//------------------------------
	input	logic	s_axilite_awvalid,
	output	logic	s_axilite_awready,
	input	axil_pkg::axil_addr_t	s_axilite_awaddr,   // Low 2 bits ignored
	input	logic	s_axilite_wvalid,
	output	logic	s_axilite_wready,
	input	axil_pkg::axil_data_t	s_axilite_wdata,
	input	axil_pkg::axil_strb_t	s_axilite_wstrb,
	output	logic	s_axilite_bvalid,
	input	logic	s_axilite_bready,
	output	axil_pkg::axil_resp_t	s_axilite_bresp,
	input	logic	s_axilite_arvalid,
	output	logic	s_axilite_arready,
	input	axil_pkg::axil_addr_t	s_axilite_araddr,
	output	logic	s_axilite_rvalid,
	input	logic	s_axilite_rready,
	output	axil_pkg::axil_data_t	s_axilite_rdata,
	output	axil_pkg::axil_resp_t	s_axilite_rresp,

	//------------------------------
	// AXI-stream
	//------------------------------
	output	logic	s_axis_tready,
	input	logic	s_axis_tvalid,
	input	thr_cfg_pkg::s_tdata_t	s_axis_tdata,
	input	logic	m_axis_tready,
	output	logic	m_axis_tvalid,
	output	thr_cfg_pkg::m_tdata_t	m_axis_tdata
);
	import thr_cfg_pkg::*;

	// Config path
	logic	cfg_en;
	logic	cfg_we;
	chan_t	cfg_ch;
	tidx_t	cfg_idx;
	sample_t	cfg_d;
	logic	cfg_rack;
	sample_t	cfg_q;

	// Lookup path
	chan_t	lk_ch;
	sample_t [thr_per_ch-1:0]	lk_thr;

	axil_cfg_bridge bridge0 (
		.ap_clk, .reset,
		.s_axilite_awvalid, .s_axilite_awready, .s_axilite_awaddr,
		.s_axilite_wvalid, .s_axilite_wready, .s_axilite_wdata, .s_axilite_wstrb,
		.s_axilite_bvalid, .s_axilite_bready, .s_axilite_bresp,
		.s_axilite_arvalid, .s_axilite_arready, .s_axilite_araddr,
		.s_axilite_rvalid, .s_axilite_rready, .s_axilite_rdata, .s_axilite_rresp,
		.cfg_en, .cfg_we, .cfg_ch, .cfg_idx, .cfg_d,
		.cfg_rack, .cfg_q
	);

	threshold_store store0 (
		.ap_clk, .reset,
		.cfg_en, .cfg_we, .cfg_ch, .cfg_idx, .cfg_d,
		.cfg_rack, .cfg_q,
		.lk_ch, .lk_thr
	);

	threshold_pipe pipe0 (
		.ap_clk, .reset,
		.lk_ch, .lk_thr,
		.s_axis_tready, .s_axis_tvalid, .s_axis_tdata,
		.m_axis_tready, .m_axis_tvalid, .m_axis_tdata
	);

endmodule : thresholding_axi

//--- thresholding_axi.f
logic/thr_cfg_pkg.sv
logic/axil_pkg.sv
logic/axil_cfg_bridge.sv
logic/threshold_store.sv
logic/threshold_pipe.sv
logic/thresholding_axi.sv
dv/thresholding_axi_tb.sv
